// ==== hw/apf_io_pkg.sv ====
/*
 * shared types and constants for the bridge handoff block
 * bridge regions, captured request, option registers, rom masks,
 * pad key and joystick words, register offsets and reset values
 */

package apf_io_pkg;

	// address decode
	localparam logic [7:0]  addr_cfg_top  = 8'hF0;
	localparam logic [7:0]  addr_p2_top   = 8'h10;
	localparam logic [7:0]  addr_v1_top   = 8'h20;
	// 0x10F80000 and up, upper 13 bits
	localparam logic [12:0] addr_mrom_hi  = 13'h021F;

	// offsets inside the config window
	localparam logic [23:0] reg_map_1         = 24'h000000;
	localparam logic [23:0] reg_map_2         = 24'h000004;
	localparam logic [23:0] reg_dipsw         = 24'h000008;
	localparam logic [23:0] reg_system_type   = 24'h00000C;
	localparam logic [23:0] reg_memory_card   = 24'h000010;
	localparam logic [23:0] reg_use_mouse     = 24'h000014;
	localparam logic [23:0] reg_video_mode    = 24'h000018;
	localparam logic [23:0] reg_ch_enable     = 24'h00001C;
	localparam logic [23:0] reg_snd_enable    = 24'h000020;
	localparam logic [23:0] reg_pchip_main    = 24'h000024;
	localparam logic [23:0] reg_use_pcm       = 24'h000028;
	localparam logic [23:0] reg_pchip_sub     = 24'h00002C;
	localparam logic [23:0] reg_cmc_chip      = 24'h000030;
	localparam logic [23:0] reg_screen_x_pos  = 24'h000034;
	localparam logic [23:0] reg_screen_y_pos  = 24'h000038;
	localparam logic [23:0] reg_v2_offset     = 24'h00003C;
	localparam logic [23:0] reg_cart_chip     = 24'h000040;

	// pad layouts, anything else is the default pad
	localparam logic [3:0] layout_neogeo    = 4'd1;
	localparam logic [3:0] layout_neogeo_cd = 4'd2;

	// non-zero reset values
	localparam logic [7:0] rst_dipsw       = 8'hFF;
	localparam logic [1:0] rst_system_type = 2'd1;
	localparam logic [5:0] rst_ch_enable   = 6'h3F;
	localparam logic [3:0] rst_snd_enable  = 4'hF;

	typedef enum logic [2:0] {
		region_none,
		region_config,
		region_p2rom,
		region_mrom,
		region_v1rom
	} bridge_region_e;

	typedef struct packed {
		logic           wr;
		logic           rd;
		logic [31:0]    addr;
		logic [31:0]    data;
		bridge_region_e region;
	} bridge_req_t;

	typedef struct packed {
		logic [7:0]  dipsw;
		logic [1:0]  system_type;
		logic [1:0]  memory_card_enable;
		logic [1:0]  use_mouse;
		logic        video_mode;
		logic [5:0]  ch_enable;
		logic [3:0]  snd_enable;
		logic        use_pcm;
		logic [1:0]  cmc_chip;
		logic [1:0]  cart_chip;
		logic [31:0] screen_x_pos;
		logic [31:0] screen_y_pos;
		logic [23:0] v2_offset;
	} core_cfg_t;

	localparam core_cfg_t cfg_reset = '{
		dipsw:       rst_dipsw,
		system_type: rst_system_type,
		ch_enable:   rst_ch_enable,
		snd_enable:  rst_snd_enable,
		default:     '0
	};

	typedef struct packed {
		logic [22:0] p2rom;
		logic [18:0] mrom;
		logic [23:0] v1rom;
	} rom_mask_t;

	// key bit 15 down to bit 0
	typedef struct packed {
		logic face_start;
		logic face_select;
		logic trig_r3;
		logic trig_l3;
		logic trig_r2;
		logic trig_l2;
		logic trig_r1;
		logic trig_l1;
		logic face_y;
		logic face_x;
		logic face_b;
		logic face_a;
		logic dpad_right;
		logic dpad_left;
		logic dpad_down;
		logic dpad_up;
	} pad_keys_t;

	typedef struct packed {
		logic select;
		logic start;
		logic btn_d;
		logic btn_c;
		logic btn_b;
		logic btn_a;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_word_t;

endpackage

// ==== hw/apf_io_top.sv ====
/*
 * bridge handoff top level
 * capture stage, option registers, three rom masks, pad mapper
 */

`timescale 1ns/1ps

module apf_io_top import apf_io_pkg::*; (
	input  logic        clk_74a,
	input  logic        reset_l_main,
	input  logic [31:0] bridge_addr,
	input  logic [31:0] bridge_wr_data,
	input  logic        bridge_wr,
	input  logic        bridge_rd,
	output logic [31:0] bridge_rd_data,
	input  pad_keys_t   cont1_key,
	input  pad_keys_t   cont2_key,
	input  logic        dataslot_allcomplete,
	input  logic        core_reset_n,
	output joy_word_t   joystick_0,
	output joy_word_t   joystick_1,
	output logic        start_system,
	output core_cfg_t   core_cfg,
	output logic [2:0]  cart_pchip,
	output rom_mask_t   rom_masks
);

	bridge_req_t req;
	logic [3:0]  map_1;
	logic [3:0]  map_2;
	logic [22:0] p2rom_mask;
	logic [18:0] mrom_mask;
	logic [23:0] v1rom_mask;

	bridge_capture u_capture (
		.clk_74a        (clk_74a),
		.reset_l_main   (reset_l_main),
		.bridge_addr    (bridge_addr),
		.bridge_wr_data (bridge_wr_data),
		.bridge_wr      (bridge_wr),
		.bridge_rd      (bridge_rd),
		.req            (req)
	);

	// hold key is trigger l1 on pad 1
	core_config_regs u_cfg (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.req                  (req),
		.cont1_start_hold     (cont1_key.trig_l1),
		.dataslot_allcomplete (dataslot_allcomplete),
		.core_reset_n         (core_reset_n),
		.core_cfg             (core_cfg),
		.map_1                (map_1),
		.map_2                (map_2),
		.cart_pchip           (cart_pchip),
		.start_system         (start_system),
		.bridge_rd_data       (bridge_rd_data)
	);

	rom_size_mask #(.MASK_W(23)) u_p2rom_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.req          (req),
		.region       (region_p2rom),
		.mask         (p2rom_mask)
	);

	rom_size_mask #(.MASK_W(19)) u_mrom_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.req          (req),
		.region       (region_mrom),
		.mask         (mrom_mask)
	);

	rom_size_mask #(.MASK_W(24)) u_v1rom_mask (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.req          (req),
		.region       (region_v1rom),
		.mask         (v1rom_mask)
	);

	assign rom_masks = '{p2rom: p2rom_mask, mrom: mrom_mask, v1rom: v1rom_mask};

	pad_layout_mapper u_pads (
		.clk_74a      (clk_74a),
		.reset_l_main (reset_l_main),
		.cont1_key    (cont1_key),
		.cont2_key    (cont2_key),
		.map_1        (map_1),
		.map_2        (map_2),
		.joystick_0   (joystick_0),
		.joystick_1   (joystick_1)
	);

endmodule

// ==== hw/bridge_capture.sv ====
/*
 * bridge input stage
 * registers one bus cycle and tags it with its target region
 */

`timescale 1ns/1ps

module bridge_capture import apf_io_pkg::*; (
	input  logic        clk_74a,
	input  logic        reset_l_main,
	input  logic [31:0] bridge_addr,
	input  logic [31:0] bridge_wr_data,
	input  logic        bridge_wr,
	input  logic        bridge_rd,
	output bridge_req_t req
);

	logic           wr_q;
	logic           rd_q;
	bridge_region_e region_d;
	bridge_region_e region_q;
	logic [31:0]    addr_q;
	logic [31:0]    data_q;

	// M rom sits inside the 0x10 byte with bit 23 set, so no overlap with P2
	always_comb begin
		if (bridge_addr[31:24] == addr_cfg_top)
			region_d = region_config;
		else if (bridge_addr[31:24] == addr_p2_top && !bridge_addr[23])
			region_d = region_p2rom;
		else if (bridge_addr[31:19] == addr_mrom_hi)
			region_d = region_mrom;
		else if (bridge_addr[31:24] == addr_v1_top)
			region_d = region_v1rom;
		else
			region_d = region_none;
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			wr_q     <= 1'b0;
			rd_q     <= 1'b0;
			region_q <= region_none;
		end else begin
			wr_q     <= bridge_wr;
			rd_q     <= bridge_rd;
			region_q <= region_d;
		end
	end

	always_ff @(posedge clk_74a) begin
		addr_q <= bridge_addr;
		data_q <= bridge_wr_data;
	end

	assign req = '{wr: wr_q, rd: rd_q, addr: addr_q, data: data_q, region: region_q};

	// host strobes are exclusive
	a_wr_rd_exclusive: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		!(bridge_wr && bridge_rd))
		else $error("bridge_wr and bridge_rd high together");

endmodule

// ==== hw/core_config_regs.sv ====
/*
 * core option registers
 * config writes, read-back register, protection chip code, start level
 */

`timescale 1ns/1ps

module core_config_regs import apf_io_pkg::*; (
	input  logic        clk_74a,
	input  logic        reset_l_main,
	input  bridge_req_t req,
	input  logic        cont1_start_hold,
	input  logic        dataslot_allcomplete,
	input  logic        core_reset_n,
	output core_cfg_t   core_cfg,
	output logic [3:0]  map_1,
	output logic [3:0]  map_2,
	output logic [2:0]  cart_pchip,
	output logic        start_system,
	output logic [31:0] bridge_rd_data
);

	logic        pchip_main;
	logic [2:0]  pchip_sub;
	logic [31:0] rd_value;
	logic        cfg_wr;

	assign cfg_wr = req.wr && (req.region == region_config);

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			core_cfg   <= cfg_reset;
			map_1      <= '0;
			map_2      <= '0;
			pchip_main <= 1'b0;
			pchip_sub  <= '0;
		end else if (cfg_wr) begin
			case (req.addr[23:0])
				reg_map_1:        map_1                       <= req.data[3:0];
				reg_map_2:        map_2                       <= req.data[3:0];
				reg_dipsw:        core_cfg.dipsw              <= req.data[7:0];
				reg_system_type:  core_cfg.system_type        <= req.data[1:0];
				reg_memory_card:  core_cfg.memory_card_enable <= req.data[1:0];
				reg_use_mouse:    core_cfg.use_mouse          <= req.data[1:0];
				reg_video_mode:   core_cfg.video_mode         <= req.data[0];
				reg_ch_enable:    core_cfg.ch_enable          <= req.data[5:0];
				reg_snd_enable:   core_cfg.snd_enable         <= req.data[3:0];
				reg_pchip_main:   pchip_main                  <= req.data[0];
				reg_use_pcm:      core_cfg.use_pcm            <= req.data[0];
				reg_pchip_sub:    pchip_sub                   <= req.data[2:0];
				reg_cmc_chip:     core_cfg.cmc_chip           <= req.data[1:0];
				reg_screen_x_pos: core_cfg.screen_x_pos       <= req.data;
				reg_screen_y_pos: core_cfg.screen_y_pos       <= req.data;
				reg_v2_offset:    core_cfg.v2_offset          <= req.data[23:0];
				reg_cart_chip:    core_cfg.cart_chip          <= req.data[1:0];
				default: ;
			endcase
		end
	end

	// unknown offsets fall back to map 1
	always_comb begin
		case (req.addr[23:0])
			reg_map_1:        rd_value = 32'(map_1);
			reg_map_2:        rd_value = 32'(map_2);
			reg_dipsw:        rd_value = 32'(core_cfg.dipsw);
			reg_system_type:  rd_value = 32'(core_cfg.system_type);
			reg_memory_card:  rd_value = 32'(core_cfg.memory_card_enable);
			reg_use_mouse:    rd_value = 32'(core_cfg.use_mouse);
			reg_video_mode:   rd_value = 32'(core_cfg.video_mode);
			reg_ch_enable:    rd_value = 32'(core_cfg.ch_enable);
			reg_snd_enable:   rd_value = 32'(core_cfg.snd_enable);
			reg_pchip_main:   rd_value = 32'(pchip_main);
			reg_use_pcm:      rd_value = 32'(core_cfg.use_pcm);
			reg_pchip_sub:    rd_value = 32'(pchip_sub);
			reg_cmc_chip:     rd_value = 32'(core_cfg.cmc_chip);
			reg_screen_x_pos: rd_value = core_cfg.screen_x_pos;
			reg_screen_y_pos: rd_value = core_cfg.screen_y_pos;
			reg_v2_offset:    rd_value = 32'(core_cfg.v2_offset);
			reg_cart_chip:    rd_value = 32'(core_cfg.cart_chip);
			default:          rd_value = 32'(map_1);
		endcase
	end

	// memory regions are not served here and read as zero
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			bridge_rd_data <= '0;
		else if (req.rd)
			bridge_rd_data <= (req.region == region_config) ? rd_value : '0;
	end

	// main chip wins over the sub selection
	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			cart_pchip <= '0;
		else if (pchip_main)
			cart_pchip <= 3'd2;
		else if (pchip_sub >= 3'd1 && pchip_sub <= 3'd5)
			cart_pchip <= pchip_sub + 3'd2;
		else
			cart_pchip <= 3'd0;
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			start_system <= 1'b0;
		else
			start_system <= dataslot_allcomplete && core_reset_n && !cont1_start_hold;
	end

	// code 1 has no chip behind it
	a_pchip_code: assert property (@(posedge clk_74a) disable iff (!reset_l_main)
		cart_pchip != 3'd1)
		else $error("cart_pchip took reserved code 1");

endmodule

// ==== hw/pad_layout_mapper.sv ====
/*
 * controller to joystick mapping
 * face buttons reordered per layout select, two pads
 */

`timescale 1ns/1ps

module pad_layout_mapper import apf_io_pkg::*; (
	input  logic       clk_74a,
	input  logic       reset_l_main,
	input  pad_keys_t  cont1_key,
	input  pad_keys_t  cont2_key,
	input  logic [3:0] map_1,
	input  logic [3:0] map_2,
	output joy_word_t  joystick_0,
	output joy_word_t  joystick_1
);

	function automatic joy_word_t map_pad(input pad_keys_t k, input logic [3:0] layout);
		joy_word_t j;
		j.select = k.face_select;
		j.start  = k.face_start;
		j.up     = k.dpad_up;
		j.down   = k.dpad_down;
		j.left   = k.dpad_left;
		j.right  = k.dpad_right;
		case (layout)
			layout_neogeo: begin
				j.btn_d = k.face_a;
				j.btn_c = k.face_x;
				j.btn_b = k.face_b;
				j.btn_a = k.face_y;
			end
			layout_neogeo_cd: begin
				j.btn_d = k.face_x;
				j.btn_c = k.face_y;
				j.btn_b = k.face_a;
				j.btn_a = k.face_b;
			end
			// plain pad order
			default: begin
				j.btn_d = k.face_y;
				j.btn_c = k.face_x;
				j.btn_b = k.face_b;
				j.btn_a = k.face_a;
			end
		endcase
		return j;
	endfunction

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main) begin
			joystick_0 <= '0;
			joystick_1 <= '0;
		end else begin
			joystick_0 <= map_pad(cont1_key, map_1);
			joystick_1 <= map_pad(cont2_key, map_2);
		end
	end

endmodule

// ==== hw/rom_size_mask.sv ====
/*
 * upload size mask
 * fills every bit below the highest set upload address bit
 */

`timescale 1ns/1ps

module rom_size_mask import apf_io_pkg::*; #(
	parameter int MASK_W = 23
) (
	input  logic              clk_74a,
	input  logic              reset_l_main,
	input  bridge_req_t       req,
	input  bridge_region_e    region,
	output logic [MASK_W-1:0] mask
);

	logic [MASK_W-1:0] smear;

	// or-chain from the top bit down
	always_comb begin
		smear[MASK_W-1] = req.addr[MASK_W-1];
		for (int i = MASK_W - 2; i >= 0; i--) begin
			smear[i] = smear[i+1] | req.addr[i];
		end
	end

	always_ff @(posedge clk_74a or negedge reset_l_main) begin
		if (!reset_l_main)
			mask <= '0;
		else if (req.wr && req.region == region)
			mask <= smear;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the apf_io testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module apf_io_tb -o apf_io_sim

./obj_dir/apf_io_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
grep -q "TEST OK" sim.log

// ==== include/apf_io_tests.svh ====
/*
 * directed tests and reference helpers for the handoff block
 * bus cycles, reset state, config registers, masks, chip code, layouts
 */

`ifndef APF_IO_TESTS_SVH
`define APF_IO_TESTS_SVH

	// all driving and sampling happens 2 ns after a rising edge
	task automatic tick();
		@(posedge clk_74a);
		#2;
	endtask

	task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
		bridge_addr    = addr;
		bridge_wr_data = data;
		bridge_wr      = 1'b1;
		tick();
		bridge_wr = 1'b0;
		tick();
	endtask

	task automatic bus_read(input logic [31:0] addr);
		bridge_addr = addr;
		bridge_rd   = 1'b1;
		tick();
		bridge_rd = 1'b0;
		tick();
	endtask

	// stored field width for each register index
	function automatic int field_width(input int idx);
		case (idx)
			0, 1, 8:  return 4;
			2:        return 8;
			3, 4, 5:  return 2;
			6, 9, 10: return 1;
			7:        return 6;
			11:       return 3;
			12, 16:   return 2;
			13, 14:   return 32;
			default:  return 24;
		endcase
	endfunction

	function automatic logic [31:0] readback_value(input int idx, input logic [31:0] data);
		logic [63:0] keep;
		keep = (64'h1 << field_width(idx)) - 64'h1;
		return data & keep[31:0];
	endfunction

	function automatic core_cfg_t apply_cfg_write(input core_cfg_t c, input int idx,
		input logic [31:0] d);
		core_cfg_t n;
		n = c;
		case (idx)
			2:  n.dipsw              = d[7:0];
			3:  n.system_type        = d[1:0];
			4:  n.memory_card_enable = d[1:0];
			5:  n.use_mouse          = d[1:0];
			6:  n.video_mode         = d[0];
			7:  n.ch_enable          = d[5:0];
			8:  n.snd_enable         = d[3:0];
			10: n.use_pcm            = d[0];
			12: n.cmc_chip           = d[1:0];
			13: n.screen_x_pos       = d;
			14: n.screen_y_pos       = d;
			15: n.v2_offset          = d[23:0];
			16: n.cart_chip          = d[1:0];
			default: ;
		endcase
		return n;
	endfunction

	// ones from the highest set bit below w down to bit 0
	function automatic logic [31:0] smear_down(input logic [31:0] a, input int w);
		logic [31:0] m;
		int          top;
		top = -1;
		for (int i = 0; i < w; i++)
			if (a[i])
				top = i;
		m = '0;
		for (int i = 0; i <= top; i++)
			m[i] = 1'b1;
		return m;
	endfunction

	function automatic logic [2:0] chip_code(input logic main, input logic [2:0] sub);
		if (main)
			return 3'd2;
		case (sub)
			3'd1:    return 3'd3;
			3'd2:    return 3'd4;
			3'd3:    return 3'd5;
			3'd4:    return 3'd6;
			3'd5:    return 3'd7;
			default: return 3'd0;
		endcase
	endfunction

	// select, start, D C B A, up down left right
	function automatic joy_word_t layout_joy(input logic [15:0] k, input logic [3:0] layout);
		logic [3:0] dcba;
		case (layout)
			4'd1:    dcba = {k[4], k[6], k[5], k[7]};
			4'd2:    dcba = {k[6], k[7], k[4], k[5]};
			default: dcba = {k[7], k[6], k[5], k[4]};
		endcase
		return {k[14], k[15], dcba, k[0], k[1], k[2], k[3]};
	endfunction

	task automatic reset_state();
		cfg_model             = '0;
		cfg_model.dipsw       = 8'hFF;
		cfg_model.system_type = 2'd1;
		cfg_model.ch_enable   = 6'h3F;
		cfg_model.snd_enable  = 4'hF;
		mask_model            = '0;
		check_cfg("reset cfg", cfg_model, core_cfg);
		check_mask("reset masks", mask_model, rom_masks);
		check_word("reset start", 32'h0, {31'h0, start_system});
		check_word("reset pchip", 32'h0, {29'h0, cart_pchip});
		check_word("reset rd data", 32'h0, bridge_rd_data);
		check_joy("reset joy 0", '0, joystick_0);
		check_joy("reset joy 1", '0, joystick_1);
	endtask

	task automatic config_write_read();
		logic [31:0] data;
		logic [31:0] addr;
		logic [31:0] map1_data;
		map1_data = '0;
		for (int idx = 0; idx < 17; idx++) begin
			data = $random(seed);
			addr = 32'hF000_0000 | (idx * 4);
			// map 1 kept non-zero so the zero reads below can tell
			if (idx == 0) begin
				data[0]   = 1'b1;
				map1_data = data;
			end
			bus_write(addr, data);
			cfg_model = apply_cfg_write(cfg_model, idx, data);
			check_cfg($sformatf("cfg write %0d", idx), cfg_model, core_cfg);
			bus_read(addr);
			check_word($sformatf("cfg read %0d", idx), readback_value(idx, data), bridge_rd_data);
		end
		// unknown offset falls back to map 1
		bus_read(32'hF000_0044);
		check_word("cfg read unknown", readback_value(0, map1_data), bridge_rd_data);
		bus_read(32'h3000_0000);
		check_word("read none region", 32'h0, bridge_rd_data);
		bus_read(32'h1000_0000);
		check_word("read p2 region", 32'h0, bridge_rd_data);
	endtask

	task automatic mask_from_uploads();
		logic [31:0] r;
		logic [31:0] addr;
		logic [31:0] sm;
		for (int s = 0; s < mask_samples; s++) begin
			r    = $random(seed);
			addr = {8'h10, 1'b0, r[22:0] >> r[31:27]};
			bus_write(addr, r);
			sm               = smear_down(addr, 23);
			mask_model.p2rom = sm[22:0];
			check_mask($sformatf("p2 upload %h", addr), mask_model, rom_masks);
			r    = $random(seed);
			addr = {13'h021F, r[18:0] >> r[31:27]};
			bus_write(addr, r);
			sm              = smear_down(addr, 19);
			mask_model.mrom = sm[18:0];
			check_mask($sformatf("m upload %h", addr), mask_model, rom_masks);
			r    = $random(seed);
			addr = {8'h20, r[23:0] >> r[31:27]};
			bus_write(addr, r);
			sm               = smear_down(addr, 24);
			mask_model.v1rom = sm[23:0];
			check_mask($sformatf("v1 upload %h", addr), mask_model, rom_masks);
		end
		r = $random(seed);
		bus_write({8'h30, r[23:0]}, r);
		check_mask("none region upload", mask_model, rom_masks);
		// bit 23 set but below the M window
		bus_write({8'h10, 1'b1, 4'h0, r[18:0]}, r);
		check_mask("gap upload", mask_model, rom_masks);
		bus_write(32'h1040_0000, r);
		mask_model.p2rom = 23'h7FFFFF;
		check_mask("p2 full upload", mask_model, rom_masks);
		bus_write(32'h1000_0000, r);
		mask_model.p2rom = '0;
		check_mask("p2 zero upload", mask_model, rom_masks);
	endtask

	task automatic pchip_encoding();
		bus_write(32'hF000_002C, 32'h0);
		bus_write(32'hF000_0024, 32'h1);
		tick();
		check_word("pchip main", {29'h0, chip_code(1'b1, 3'd0)}, {29'h0, cart_pchip});
		bus_write(32'hF000_002C, 32'h4);
		tick();
		check_word("pchip main over sub", {29'h0, chip_code(1'b1, 3'd4)}, {29'h0, cart_pchip});
		bus_write(32'hF000_0024, 32'h0);
		for (int sub = 0; sub < 8; sub++) begin
			bus_write(32'hF000_002C, sub);
			tick();
			check_word($sformatf("pchip sub %0d", sub), {29'h0, chip_code(1'b0, sub[2:0])},
				{29'h0, cart_pchip});
		end
	endtask

	task automatic layout_mapping();
		logic [3:0]  layouts [3];
		logic [31:0] r;
		layouts = '{4'd1, 4'd2, 4'd0};
		for (int l = 0; l < 3; l++) begin
			r         = $random(seed);
			cont1_key = r[15:0];
			cont2_key = r[31:16];
			bus_write(32'hF000_0000, {28'h0, layouts[l]});
			bus_write(32'hF000_0004, {28'h0, layouts[(l + 1) % 3]});
			tick();
			check_joy($sformatf("layout %0d change 0", l), layout_joy(cont1_key, layouts[l]),
				joystick_0);
			check_joy($sformatf("layout %0d change 1", l),
				layout_joy(cont2_key, layouts[(l + 1) % 3]), joystick_1);
			for (int s = 0; s < key_samples; s++) begin
				r         = $random(seed);
				cont1_key = r[15:0];
				cont2_key = r[31:16];
				tick();
				check_joy($sformatf("layout %0d keys 0", l), layout_joy(r[15:0], layouts[l]),
					joystick_0);
				check_joy($sformatf("layout %0d keys 1", l),
					layout_joy(r[31:16], layouts[(l + 1) % 3]), joystick_1);
			end
		end
	endtask

	task automatic start_level();
		logic [2:0] combo;
		for (int c = 0; c < 8; c++) begin
			combo                = c[2:0];
			dataslot_allcomplete = combo[0];
			core_reset_n         = combo[1];
			cont1_key[8]         = combo[2];
			tick();
			check_word($sformatf("start combo %0d", c),
				{31'h0, combo[0] & combo[1] & ~combo[2]}, {31'h0, start_system});
		end
		dataslot_allcomplete = 1'b0;
		core_reset_n         = 1'b0;
	endtask

`endif

// ==== tb/apf_io_tb.sv ====
/*
 * testbench for the bridge handoff top level
 * clock, reset, DUT, compare tasks, watchdog and summary
 */

`timescale 1ns/1ps

module apf_io_tb import apf_io_pkg::*; ();

	localparam int mask_samples = 6;
	localparam int key_samples  = 6;
	// reset, config, masks, pchip, layouts, start level
	localparam int run_cycles = 12 + (17 * 4 + 8) + (mask_samples * 6 + 8) + (12 * 2 + 10)
		+ 3 * (5 + key_samples * 1) + 10;
	localparam int watchdog_cycles = run_cycles * 2 + 50;

	logic        clk_74a;
	logic        reset_l_main;
	logic [31:0] bridge_addr;
	logic [31:0] bridge_wr_data;
	logic        bridge_wr;
	logic        bridge_rd;
	logic [31:0] bridge_rd_data;
	pad_keys_t   cont1_key;
	pad_keys_t   cont2_key;
	logic        dataslot_allcomplete;
	logic        core_reset_n;
	joy_word_t   joystick_0;
	joy_word_t   joystick_1;
	logic        start_system;
	core_cfg_t   core_cfg;
	logic [2:0]  cart_pchip;
	rom_mask_t   rom_masks;

	integer      seed;
	int          cfg_errors;
	int          mask_errors;
	int          joy_errors;
	int          word_errors;
	core_cfg_t   cfg_model;
	rom_mask_t   mask_model;

	apf_io_top uut (
		.clk_74a              (clk_74a),
		.reset_l_main         (reset_l_main),
		.bridge_addr          (bridge_addr),
		.bridge_wr_data       (bridge_wr_data),
		.bridge_wr            (bridge_wr),
		.bridge_rd            (bridge_rd),
		.bridge_rd_data       (bridge_rd_data),
		.cont1_key            (cont1_key),
		.cont2_key            (cont2_key),
		.dataslot_allcomplete (dataslot_allcomplete),
		.core_reset_n         (core_reset_n),
		.joystick_0           (joystick_0),
		.joystick_1           (joystick_1),
		.start_system         (start_system),
		.core_cfg             (core_cfg),
		.cart_pchip           (cart_pchip),
		.rom_masks            (rom_masks)
	);

	initial begin
		clk_74a = 1'b0;
		forever #20 clk_74a = ~clk_74a;
	end

	task automatic check_cfg(input string name, input core_cfg_t exp, input core_cfg_t act);
		if (act !== exp) begin
			cfg_errors++;
			$display("Error %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input rom_mask_t exp, input rom_mask_t act);
		if (act.p2rom !== exp.p2rom) begin
			mask_errors++;
			$display("Error %s p2rom: expected %h actual %h", name, exp.p2rom, act.p2rom);
		end
		if (act.mrom !== exp.mrom) begin
			mask_errors++;
			$display("Error %s mrom: expected %h actual %h", name, exp.mrom, act.mrom);
		end
		if (act.v1rom !== exp.v1rom) begin
			mask_errors++;
			$display("Error %s v1rom: expected %h actual %h", name, exp.v1rom, act.v1rom);
		end
	endtask

	task automatic check_joy(input string name, input joy_word_t exp, input joy_word_t act);
		if (act !== exp) begin
			joy_errors++;
			$display("Error %s: expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			word_errors++;
			$display("Error %s: expected %h actual %h", name, exp, act);
		end
	endtask

	`include "apf_io_tests.svh"

	// ends a run that stops making progress
	initial begin
		repeat (watchdog_cycles) @(posedge clk_74a);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		seed                 = 20;
		reset_l_main         = 1'b0;
		bridge_addr          = '0;
		bridge_wr_data       = '0;
		bridge_wr            = 1'b0;
		bridge_rd            = 1'b0;
		cont1_key            = '0;
		cont2_key            = '0;
		dataslot_allcomplete = 1'b0;
		core_reset_n         = 1'b0;
		repeat (8) @(posedge clk_74a);
		#2;
		reset_l_main = 1'b1;
		tick();

		reset_state();
		config_write_read();
		mask_from_uploads();
		pchip_encoding();
		layout_mapping();
		start_level();

		$display("errors: cfg %0d mask %0d joy %0d word %0d",
			cfg_errors, mask_errors, joy_errors, word_errors);
		if (cfg_errors + mask_errors + joy_errors + word_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+include
hw/apf_io_pkg.sv
hw/bridge_capture.sv
hw/core_config_regs.sv
hw/rom_size_mask.sv
hw/pad_layout_mapper.sv
hw/apf_io_top.sv
tb/apf_io_tb.sv
